/* rtl/dpa_settings.svh */
`ifndef DPA_SETTINGS_SVH
`define DPA_SETTINGS_SVH

// bus widths
`define IM_AW 20
`define PIX_W 24
`define CR_AW 9
`define CR_DW 13

// framebuffer and source geometry
`define FB_DIM 256
`define SRC_BIG 512 // size code for the 2x2 downscale

// glyph rom layout, one word per glyph row
`define GLYPH_W 13
`define GLYPH_H 24
`define COLON_GLYPH 10

// clock window, lower right corner of the frame
`define OVL_X 152
`define OVL_Y 232
`define COLOR_ON 24'hffffff
`define COLOR_OFF 24'h111111

// header word addresses
`define HDR_TIME 0
`define HDR_FB 1
`define HDR_PHOTO 2
`define HDR_SIZE 3

`endif

/* rtl/dpa_pkg.sv */
`include "dpa_settings.svh"
`default_nettype none

package dpa_pkg;

	typedef logic [`PIX_W-1:0] pixel_t; // r, g, b bytes
	typedef logic [`IM_AW-1:0] im_addr_t;
	typedef logic [`CR_AW-1:0] cr_addr_t;
	typedef logic [3:0] bcd_t;

	// memory peers, highest priority first
	typedef enum logic [1:0] {
		PEER_HDR,
		PEER_OVL,
		PEER_SCL
	} peer_e;

	typedef enum logic {
		MODE_COPY, // every pixel of a 256 source
		MODE_AVG   // 2x2 average of a 512 source
	} scale_mode_e;

	typedef enum logic [1:0] {H_IDLE, H_READ, H_WAIT, H_DONE} hdr_state_e;
	typedef enum logic [2:0] {S_IDLE, S_READ, S_WAIT, S_WRITE, S_DONE} scale_state_e;
	typedef enum logic [2:0] {O_IDLE, O_ADDR, O_WAIT, O_LOAD, O_DRAW} ovl_state_e;

endpackage

`default_nettype wire

/* rtl/mem_arbiter.sv */
`include "dpa_settings.svh"
`default_nettype none

module mem_arbiter (
	input  logic              clk,
	input  logic              reset,
	input  logic              hdr_req_valid,
	input  dpa_pkg::im_addr_t hdr_req_addr,
	input  logic              hdr_req_write,
	input  dpa_pkg::pixel_t   hdr_req_data,
	output logic              hdr_req_ready,
	output logic              hdr_rsp_valid,
	input  logic              ovl_req_valid,
	input  dpa_pkg::im_addr_t ovl_req_addr,
	input  logic              ovl_req_write,
	input  dpa_pkg::pixel_t   ovl_req_data,
	output logic              ovl_req_ready,
	output logic              ovl_rsp_valid,
	input  logic              scl_req_valid,
	input  dpa_pkg::im_addr_t scl_req_addr,
	input  logic              scl_req_write,
	input  dpa_pkg::pixel_t   scl_req_data,
	output logic              scl_req_ready,
	output logic              scl_rsp_valid,
	output dpa_pkg::im_addr_t im_a,
	output dpa_pkg::pixel_t   im_d,
	output logic              im_wen // low writes
);

	logic              gnt;
	dpa_pkg::peer_e    gnt_peer;
	dpa_pkg::im_addr_t gnt_addr;
	logic              gnt_write;
	dpa_pkg::pixel_t   gnt_data;
	logic              rd1_valid;
	logic              rd2_valid;
	dpa_pkg::peer_e    rd1_peer;
	dpa_pkg::peer_e    rd2_peer;

	// fixed priority pick
	always_comb begin
		gnt = 1'b1;
		gnt_peer = dpa_pkg::PEER_SCL;
		gnt_addr = scl_req_addr;
		gnt_write = scl_req_write;
		gnt_data = scl_req_data;
		if (hdr_req_valid) begin
			gnt_peer = dpa_pkg::PEER_HDR;
			gnt_addr = hdr_req_addr;
			gnt_write = hdr_req_write;
			gnt_data = hdr_req_data;
		end else if (ovl_req_valid) begin
			gnt_peer = dpa_pkg::PEER_OVL;
			gnt_addr = ovl_req_addr;
			gnt_write = ovl_req_write;
			gnt_data = ovl_req_data;
		end else if (!scl_req_valid) begin
			gnt = 1'b0;
		end
	end

	assign hdr_req_ready = gnt && (gnt_peer == dpa_pkg::PEER_HDR);
	assign ovl_req_ready = gnt && (gnt_peer == dpa_pkg::PEER_OVL);
	assign scl_req_ready = gnt && (gnt_peer == dpa_pkg::PEER_SCL);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			im_wen <= 1'b1;
			rd1_valid <= 1'b0;
			rd2_valid <= 1'b0;
		end else begin
			im_wen <= !(gnt && gnt_write);
			rd1_valid <= gnt && !gnt_write; // memory sees the read
			rd2_valid <= rd1_valid;         // im_q holds the data
		end
	end

	always_ff @(posedge clk) begin
		if (gnt) begin
			im_a <= gnt_addr;
			im_d <= gnt_data;
		end
		rd1_peer <= gnt_peer;
		rd2_peer <= rd1_peer;
	end

	// response goes back to whoever asked two cycles ago
	assign hdr_rsp_valid = rd2_valid && (rd2_peer == dpa_pkg::PEER_HDR);
	assign ovl_rsp_valid = rd2_valid && (rd2_peer == dpa_pkg::PEER_OVL);
	assign scl_rsp_valid = rd2_valid && (rd2_peer == dpa_pkg::PEER_SCL);

endmodule

`default_nettype wire

/* rtl/header_loader.sv */
`include "dpa_settings.svh"
`default_nettype none

module header_loader (
	input  logic                 clk,
	input  logic                 reset,
	output logic                 req_valid,
	output dpa_pkg::im_addr_t    req_addr,
	output logic                 req_write,
	output dpa_pkg::pixel_t      req_data,
	input  logic                 req_ready,
	input  logic                 rsp_valid,
	input  dpa_pkg::pixel_t      im_q,
	output logic                 cfg_valid,
	output dpa_pkg::pixel_t      time_init, // packed bcd hh mm ss
	output dpa_pkg::im_addr_t    fb_base,
	output dpa_pkg::im_addr_t    photo_addr,
	output dpa_pkg::scale_mode_e scale_mode
);

	dpa_pkg::hdr_state_e state;
	logic [1:0]          req_cnt;
	logic [1:0]          rsp_cnt;

	assign req_valid = (state == dpa_pkg::H_READ);
	assign req_addr = dpa_pkg::im_addr_t'(req_cnt); // header words sit at 0..3
	assign req_write = 1'b0;
	assign req_data = '0;
	assign cfg_valid = (state == dpa_pkg::H_DONE);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= dpa_pkg::H_IDLE;
			req_cnt <= '0;
			rsp_cnt <= '0;
		end else begin
			if (rsp_valid)
				rsp_cnt <= rsp_cnt + 2'd1;
			case (state)
				dpa_pkg::H_IDLE: state <= dpa_pkg::H_READ;
				dpa_pkg::H_READ: if (req_ready) begin
					req_cnt <= req_cnt + 2'd1;
					if (req_cnt == 2'd3)
						state <= dpa_pkg::H_WAIT;
				end
				dpa_pkg::H_WAIT: if (rsp_valid && rsp_cnt == 2'd3)
					state <= dpa_pkg::H_DONE; // last word lands with cfg_valid
				default: state <= dpa_pkg::H_DONE;
			endcase
		end
	end

	// words arrive in issue order
	always_ff @(posedge clk) begin
		if (rsp_valid) begin
			case (rsp_cnt)
				2'(`HDR_TIME):  time_init <= im_q;
				2'(`HDR_FB):    fb_base <= im_q[`IM_AW-1:0];
				2'(`HDR_PHOTO): photo_addr <= im_q[`IM_AW-1:0];
				default: scale_mode <= (im_q == `PIX_W'(`SRC_BIG)) ?
					dpa_pkg::MODE_AVG : dpa_pkg::MODE_COPY;
			endcase
		end
	end

endmodule

`default_nettype wire

/* rtl/time_counter.sv */
`include "dpa_settings.svh"
`default_nettype none

module time_counter #(
	parameter int sec_cycles = 100000
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  cfg_valid,
	input  dpa_pkg::pixel_t       time_init,
	output dpa_pkg::bcd_t [1:0]   hour, // [1] tens, [0] ones
	output dpa_pkg::bcd_t [1:0]   min,
	output dpa_pkg::bcd_t [1:0]   sec,
	output logic                  sec_tick
);

	localparam int DW = (sec_cycles > 1) ? $clog2(sec_cycles) : 1;

	logic [DW-1:0] div_cnt;
	logic          cfg_q;
	logic          running;
	logic          wrap;
	logic          s_wrap;
	logic          m_wrap;

	// one decimal digit step, back to zero after top
	function automatic dpa_pkg::bcd_t step(dpa_pkg::bcd_t d, dpa_pkg::bcd_t top);
		return (d == top) ? 4'd0 : d + 4'd1;
	endfunction

	assign wrap = running && (div_cnt == DW'(sec_cycles - 1));
	assign s_wrap = (sec == 8'h59);
	assign m_wrap = (min == 8'h59);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			div_cnt <= '0;
			cfg_q <= 1'b0;
			running <= 1'b0;
			sec_tick <= 1'b0;
			{hour, min, sec} <= '0;
		end else begin
			cfg_q <= cfg_valid;
			sec_tick <= 1'b0;
			if (cfg_valid && !cfg_q) begin // header just landed
				{hour, min, sec} <= time_init;
				div_cnt <= '0;
				running <= 1'b1;
			end else if (wrap) begin
				div_cnt <= '0;
				sec_tick <= 1'b1;
				sec[0] <= step(sec[0], 4'd9);
				if (sec[0] == 4'd9)
					sec[1] <= step(sec[1], 4'd5);
				if (s_wrap) begin
					min[0] <= step(min[0], 4'd9);
					if (min[0] == 4'd9)
						min[1] <= step(min[1], 4'd5);
				end
				if (s_wrap && m_wrap) begin
					if (hour == 8'h23) begin
						hour <= '0; // midnight
					end else begin
						hour[0] <= step(hour[0], 4'd9);
						if (hour[0] == 4'd9)
							hour[1] <= hour[1] + 4'd1;
					end
				end
			end else if (running) begin
				div_cnt <= div_cnt + DW'(1);
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/photo_scaler.sv */
`include "dpa_settings.svh"
`default_nettype none

module photo_scaler (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 cfg_valid,
	input  dpa_pkg::im_addr_t    fb_base,
	input  dpa_pkg::im_addr_t    photo_addr,
	input  dpa_pkg::scale_mode_e scale_mode,
	output logic                 req_valid,
	output dpa_pkg::im_addr_t    req_addr,
	output logic                 req_write,
	output dpa_pkg::pixel_t      req_data,
	input  logic                 req_ready,
	input  logic                 rsp_valid,
	input  dpa_pkg::pixel_t      im_q,
	output logic                 scale_done
);

	localparam int XW = $clog2(`FB_DIM);

	dpa_pkg::scale_state_e state;
	logic [XW-1:0]         x;
	logic [XW-1:0]         y;
	logic [1:0]            rd_idx;  // reads issued for this pixel
	logic [1:0]            rsp_cnt; // reads returned for this pixel
	logic [1:0]            last_idx;
	logic                  avg;
	logic [9:0]            sum_r;
	logic [9:0]            sum_g;
	logic [9:0]            sum_b;
	dpa_pkg::im_addr_t     src_off;

	assign avg = (scale_mode == dpa_pkg::MODE_AVG);
	assign last_idx = avg ? 2'd3 : 2'd0;

	// 2x2 block at (2x, 2y), stride 512; copy uses stride 256
	always_comb begin
		if (avg)
			src_off = dpa_pkg::im_addr_t'({y, rd_idx[1], x, rd_idx[0]});
		else
			src_off = dpa_pkg::im_addr_t'({y, x});
	end

	assign req_valid = (state == dpa_pkg::S_READ) || (state == dpa_pkg::S_WRITE);
	assign req_write = (state == dpa_pkg::S_WRITE);
	assign req_addr = req_write ? fb_base + dpa_pkg::im_addr_t'({y, x}) : photo_addr + src_off;
	assign req_data = avg ? {sum_r[9:2], sum_g[9:2], sum_b[9:2]} :
		{sum_r[7:0], sum_g[7:0], sum_b[7:0]};
	assign scale_done = (state == dpa_pkg::S_DONE);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= dpa_pkg::S_IDLE;
			x <= '0;
			y <= '0;
			rd_idx <= '0;
			rsp_cnt <= '0;
		end else begin
			if (rsp_valid)
				rsp_cnt <= (rsp_cnt == last_idx) ? 2'd0 : rsp_cnt + 2'd1;
			case (state)
				dpa_pkg::S_IDLE: if (cfg_valid)
					state <= dpa_pkg::S_READ;
				dpa_pkg::S_READ: if (req_ready) begin
					rd_idx <= rd_idx + 2'd1;
					if (rd_idx == last_idx) begin
						rd_idx <= '0;
						state <= dpa_pkg::S_WAIT;
					end
				end
				dpa_pkg::S_WAIT: if (rsp_valid && rsp_cnt == last_idx)
					state <= dpa_pkg::S_WRITE;
				dpa_pkg::S_WRITE: if (req_ready) begin
					x <= x + 1'b1;
					if (&x)
						y <= y + 1'b1;
					state <= (&{x, y}) ? dpa_pkg::S_DONE : dpa_pkg::S_READ;
				end
				default: state <= dpa_pkg::S_DONE; // frame stays written
			endcase
		end
	end

	// per channel sums, cleared once the pixel is written
	always_ff @(posedge clk) begin
		if (state == dpa_pkg::S_IDLE || (state == dpa_pkg::S_WRITE && req_ready)) begin
			sum_r <= '0;
			sum_g <= '0;
			sum_b <= '0;
		end else if (rsp_valid) begin
			sum_r <= sum_r + 10'(im_q[23:16]);
			sum_g <= sum_g + 10'(im_q[15:8]);
			sum_b <= sum_b + 10'(im_q[7:0]);
		end
	end

endmodule

`default_nettype wire

/* rtl/clock_overlay.sv */
`include "dpa_settings.svh"
`default_nettype none

module clock_overlay (
	input  logic                clk,
	input  logic                reset,
	input  logic                scale_done,
	input  dpa_pkg::im_addr_t   fb_base,
	input  dpa_pkg::bcd_t [1:0] hour,
	input  dpa_pkg::bcd_t [1:0] min,
	input  dpa_pkg::bcd_t [1:0] sec,
	input  logic                sec_tick,
	output dpa_pkg::cr_addr_t   cr_a,
	input  logic [`CR_DW-1:0]   cr_q,
	output logic                req_valid,
	output dpa_pkg::im_addr_t   req_addr,
	output logic                req_write,
	output dpa_pkg::pixel_t     req_data,
	input  logic                req_ready,
	output logic                frame_done
);

	localparam int N_CHARS = 8; // hh:mm:ss

	dpa_pkg::ovl_state_e state;
	dpa_pkg::bcd_t       snap [0:N_CHARS-1]; // glyph index per character
	logic                started;
	logic                pend;  // a tick is waiting for its redraw
	logic                start;
	logic [2:0]          chr;
	logic [4:0]          row;
	logic [3:0]          col;
	logic [7:0]          char_x;
	logic [7:0]          xpos;
	logic [7:0]          ypos;
	logic [`CR_DW-1:0]   row_bits;

	assign start = (state == dpa_pkg::O_IDLE) && (pend || (scale_done && !started));
	assign xpos = char_x + 8'(col);
	assign ypos = 8'(`OVL_Y) + 8'(row);

	assign req_valid = (state == dpa_pkg::O_DRAW);
	assign req_write = 1'b1;
	assign req_addr = fb_base + dpa_pkg::im_addr_t'({ypos, xpos});
	assign req_data = row_bits[`GLYPH_W - 1 - col] ? `COLOR_ON : `COLOR_OFF; // msb is leftmost

	// time is frozen for the whole redraw
	always_ff @(posedge clk) begin
		if (start) begin
			snap[0] <= hour[1];
			snap[1] <= hour[0];
			snap[2] <= 4'(`COLON_GLYPH);
			snap[3] <= min[1];
			snap[4] <= min[0];
			snap[5] <= 4'(`COLON_GLYPH);
			snap[6] <= sec[1];
			snap[7] <= sec[0];
		end
		if (state == dpa_pkg::O_LOAD)
			row_bits <= cr_q;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= dpa_pkg::O_IDLE;
			started <= 1'b0;
			pend <= 1'b0;
			chr <= '0;
			row <= '0;
			col <= '0;
			char_x <= 8'(`OVL_X);
			cr_a <= '0;
			frame_done <= 1'b0;
		end else begin
			frame_done <= 1'b0;
			if (started && sec_tick)
				pend <= 1'b1;
			else if (start)
				pend <= 1'b0;
			case (state)
				dpa_pkg::O_IDLE: if (start) begin
					started <= 1'b1;
					chr <= '0;
					row <= '0;
					col <= '0;
					char_x <= 8'(`OVL_X);
					state <= dpa_pkg::O_ADDR;
				end
				dpa_pkg::O_ADDR: begin
					cr_a <= dpa_pkg::cr_addr_t'(snap[chr] * `GLYPH_H + row);
					state <= dpa_pkg::O_WAIT;
				end
				dpa_pkg::O_WAIT: state <= dpa_pkg::O_LOAD; // rom sees cr_a
				dpa_pkg::O_LOAD: state <= dpa_pkg::O_DRAW;
				default: if (req_ready) begin
					col <= col + 4'd1;
					if (col == 4'(`GLYPH_W - 1)) begin
						col <= '0;
						row <= row + 5'd1;
						state <= dpa_pkg::O_ADDR;
						if (row == 5'(`GLYPH_H - 1)) begin
							row <= '0;
							chr <= chr + 3'd1;
							char_x <= char_x + 8'(`GLYPH_W);
							if (chr == 3'(N_CHARS - 1)) begin
								state <= dpa_pkg::O_IDLE;
								frame_done <= 1'b1;
							end
						end
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* rtl/dpa_top.sv */
`include "dpa_settings.svh"
`default_nettype none

module dpa_top #(
	parameter int sec_cycles = 100000
) (
	input  logic              clk,
	input  logic              reset,
	output dpa_pkg::im_addr_t im_a,
	input  dpa_pkg::pixel_t   im_q,
	output dpa_pkg::pixel_t   im_d,
	output logic              im_wen,
	output dpa_pkg::cr_addr_t cr_a,
	input  logic [`CR_DW-1:0] cr_q,
	output logic              frame_done
);

	logic hdr_req_valid, hdr_req_write, hdr_req_ready, hdr_rsp_valid;
	logic ovl_req_valid, ovl_req_write, ovl_req_ready;
	logic scl_req_valid, scl_req_write, scl_req_ready, scl_rsp_valid;
	dpa_pkg::im_addr_t hdr_req_addr, ovl_req_addr, scl_req_addr;
	dpa_pkg::pixel_t hdr_req_data, ovl_req_data, scl_req_data;

	logic                 cfg_valid;
	dpa_pkg::pixel_t      time_init;
	dpa_pkg::im_addr_t    fb_base;
	dpa_pkg::im_addr_t    photo_addr;
	dpa_pkg::scale_mode_e scale_mode;
	dpa_pkg::bcd_t [1:0]  hour, min, sec;
	logic                 sec_tick;
	logic                 scale_done;

	mem_arbiter u_mem_arbiter (
		.clk, .reset,
		.hdr_req_valid, .hdr_req_addr, .hdr_req_write, .hdr_req_data,
		.hdr_req_ready, .hdr_rsp_valid,
		.ovl_req_valid, .ovl_req_addr, .ovl_req_write, .ovl_req_data,
		.ovl_req_ready, .ovl_rsp_valid(), // overlay only writes
		.scl_req_valid, .scl_req_addr, .scl_req_write, .scl_req_data,
		.scl_req_ready, .scl_rsp_valid,
		.im_a, .im_d, .im_wen
	);

	header_loader u_header_loader (
		.clk, .reset,
		.req_valid(hdr_req_valid), .req_addr(hdr_req_addr), .req_write(hdr_req_write),
		.req_data(hdr_req_data), .req_ready(hdr_req_ready), .rsp_valid(hdr_rsp_valid),
		.im_q, .cfg_valid, .time_init, .fb_base, .photo_addr, .scale_mode
	);

	time_counter #(.sec_cycles(sec_cycles)) u_time_counter (
		.clk, .reset, .cfg_valid, .time_init, .hour, .min, .sec, .sec_tick
	);

	photo_scaler u_photo_scaler (
		.clk, .reset, .cfg_valid, .fb_base, .photo_addr, .scale_mode,
		.req_valid(scl_req_valid), .req_addr(scl_req_addr), .req_write(scl_req_write),
		.req_data(scl_req_data), .req_ready(scl_req_ready), .rsp_valid(scl_rsp_valid),
		.im_q, .scale_done
	);

	clock_overlay u_clock_overlay (
		.clk, .reset, .scale_done, .fb_base, .hour, .min, .sec, .sec_tick, .cr_a, .cr_q,
		.req_valid(ovl_req_valid), .req_addr(ovl_req_addr), .req_write(ovl_req_write),
		.req_data(ovl_req_data), .req_ready(ovl_req_ready), .frame_done
	);

endmodule

`default_nettype wire

/* tb/dpa_mem_model.sv */
`include "dpa_settings.svh"
`default_nettype none

// image memory and glyph rom, both with registered read data
module dpa_mem_model (
	input  logic              clk,
	input  dpa_pkg::im_addr_t im_a,
	input  dpa_pkg::pixel_t   im_d,
	input  logic              im_wen, // low writes
	output dpa_pkg::pixel_t   im_q,
	input  dpa_pkg::cr_addr_t cr_a,
	output logic [`CR_DW-1:0] cr_q
);

	// whole image address space, header at the bottom
	dpa_pkg::pixel_t   img [0:(1 << `IM_AW) - 1];
	logic [`CR_DW-1:0] rom [0:(1 << `CR_AW) - 1];

	initial begin
		im_q = '0;
		cr_q = '0;
	end

	// im_q follows im_a by one clock, old data on a same-cycle write
	always @(posedge clk) begin
		if (im_wen === 1'b0)
			img[im_a] <= im_d;
		im_q <= img[im_a];
	end

	always @(posedge clk)
		cr_q <= rom[cr_a]; // one clock like the real rom

endmodule

`default_nettype wire

/* tb/tb_dpa.sv */
`include "dpa_settings.svh"
`default_nettype none

module tb_dpa;

	localparam int SEC_CYCLES = 4000;
	localparam int MAX_REDRAWS = 120;
	localparam int DAY = 86400;
	// average scan takes 7 clocks per pixel, copy scan 4
	localparam int SCAN_CYCLES = `FB_DIM * `FB_DIM * (7 + 4);
	localparam int WATCHDOG_CYCLES = (SCAN_CYCLES + (MAX_REDRAWS + 8) * SEC_CYCLES) * 5 / 4;

	logic              clk;
	logic              reset;
	dpa_pkg::im_addr_t im_a;
	dpa_pkg::pixel_t   im_q;
	dpa_pkg::pixel_t   im_d;
	logic              im_wen;
	dpa_pkg::cr_addr_t cr_a;
	logic [`CR_DW-1:0] cr_q;
	logic              frame_done;

	dpa_pkg::im_addr_t cur_fb; // framebuffer base of the current run
	integer            seed;
	int                errors;
	int                checks;

	dpa_top #(.sec_cycles(SEC_CYCLES)) u_dpa_top (
		.clk, .reset, .im_a, .im_q, .im_d, .im_wen, .cr_a, .cr_q, .frame_done
	);

	dpa_mem_model u_mem (
		.clk, .im_a, .im_d, .im_wen, .im_q, .cr_a, .cr_q
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// reset values, and every write must land in the framebuffer
	always @(negedge clk) begin : bus_checks
		dpa_pkg::im_addr_t off;
		off = im_a - cur_fb;
		if (reset) begin
			checks += 3;
			assert (im_wen === 1'b1) else begin
				errors++;
				$display("ERR im_wen got %h exp 1 in reset", im_wen);
			end
			assert (frame_done === 1'b0) else begin
				errors++;
				$display("ERR frame_done got %h exp 0 in reset", frame_done);
			end
			assert (cr_a === '0) else begin
				errors++;
				$display("ERR cr_a got %h exp 0 in reset", cr_a);
			end
		end else if (im_wen === 1'b0) begin
			checks++;
			assert (off < 20'h10000) else begin
				errors++;
				$display("ERR im_a got %h outside frame at %h", im_a, cur_fb);
			end
		end
	end

	task automatic reset_and_load(input dpa_pkg::im_addr_t fb, input dpa_pkg::im_addr_t photo,
			input int size, input dpa_pkg::pixel_t tod);
		dpa_pkg::im_addr_t a;
		int                i;
		@(posedge clk);
		reset <= 1'b1;
		@(negedge clk);
		cur_fb = fb;
		u_mem.img[`HDR_TIME] = tod;
		u_mem.img[`HDR_FB] = dpa_pkg::pixel_t'(fb);
		u_mem.img[`HDR_PHOTO] = dpa_pkg::pixel_t'(photo);
		u_mem.img[`HDR_SIZE] = dpa_pkg::pixel_t'(size);
		for (i = 0; i < size * size; i++) begin
			a = photo + dpa_pkg::im_addr_t'(i);
			u_mem.img[a] = dpa_pkg::pixel_t'($random(seed));
		end
		for (i = 0; i < `FB_DIM * `FB_DIM; i++) begin
			a = fb + dpa_pkg::im_addr_t'(i);
			u_mem.img[a] = {4'hd, ~a}; // stale frame marker
		end
		repeat (16) @(posedge clk);
		reset <= 1'b0;
	endtask

	task automatic wait_redraw();
		@(negedge clk);
		while (frame_done !== 1'b1)
			@(negedge clk);
		@(negedge clk); // last overlay write lands on the edge in between
	endtask

	// everything outside the clock window against the source photo
	task automatic compare_frame(input dpa_pkg::im_addr_t photo, input bit avg);
		int                x, y, dx, dy;
		int                sr, sg, sb;
		dpa_pkg::pixel_t   p;
		dpa_pkg::pixel_t   want;
		dpa_pkg::pixel_t   got;
		dpa_pkg::im_addr_t a;
		for (y = 0; y < `FB_DIM; y++) begin
			for (x = 0; x < `FB_DIM; x++) begin
				if (y < `OVL_Y || x < `OVL_X) begin
					if (avg) begin
						sr = 0;
						sg = 0;
						sb = 0;
						for (dy = 0; dy < 2; dy++) begin
							for (dx = 0; dx < 2; dx++) begin
								a = photo + dpa_pkg::im_addr_t'((2 * y + dy) * 2 * `FB_DIM
									+ 2 * x + dx);
								p = u_mem.img[a];
								sr += p[23:16];
								sg += p[15:8];
								sb += p[7:0];
							end
						end
						want = {8'(sr / 4), 8'(sg / 4), 8'(sb / 4)};
					end else begin
						a = photo + dpa_pkg::im_addr_t'(y * `FB_DIM + x);
						want = u_mem.img[a];
					end
					a = cur_fb + dpa_pkg::im_addr_t'(y * `FB_DIM + x);
					got = u_mem.img[a];
					checks++;
					assert (got === want) else begin
						errors++;
						$display("ERR fb[%h] got %h exp %h", a, got, want);
					end
				end
			end
		end
	endtask

	// reads the glyphs back out of the frame, tod is -1 if unreadable
	task automatic decode_overlay(output int tod);
		logic [`CR_DW-1:0] rows [0:`GLYPH_H-1];
		int                glyph [0:7];
		int                k, r, c, g;
		int                hh, mm, ss;
		bit                same;
		bit                valid;
		dpa_pkg::pixel_t   p;
		dpa_pkg::im_addr_t a;
		valid = 1'b1;
		for (k = 0; k < 8; k++) begin
			for (r = 0; r < `GLYPH_H; r++) begin
				for (c = 0; c < `GLYPH_W; c++) begin
					a = cur_fb + dpa_pkg::im_addr_t'((`OVL_Y + r) * `FB_DIM + `OVL_X
						+ `GLYPH_W * k + c);
					p = u_mem.img[a];
					checks++;
					assert (p === `COLOR_ON || p === `COLOR_OFF) else begin
						errors++;
						$display("ERR fb[%h] got %h exp %h or %h", a, p, `COLOR_ON,
							`COLOR_OFF);
					end
					rows[r][`GLYPH_W - 1 - c] = (p === `COLOR_ON); // leftmost is msb
				end
			end
			glyph[k] = -1;
			for (g = 0; g <= `COLON_GLYPH; g++) begin
				same = 1'b1;
				for (r = 0; r < `GLYPH_H; r++)
					if (u_mem.rom[g * `GLYPH_H + r] !== rows[r])
						same = 1'b0;
				if (same && glyph[k] < 0)
					glyph[k] = g;
			end
			checks++;
			if (k == 2 || k == 5) begin
				assert (glyph[k] == `COLON_GLYPH) else begin
					errors++;
					valid = 1'b0;
					$display("overlay character %0d does not show the colon", k);
				end
			end else begin
				assert (glyph[k] >= 0 && glyph[k] <= 9) else begin
					errors++;
					valid = 1'b0;
					$display("overlay character %0d matches no digit glyph", k);
				end
			end
		end
		hh = glyph[0] * 10 + glyph[1];
		mm = glyph[3] * 10 + glyph[4];
		ss = glyph[6] * 10 + glyph[7];
		if (valid) begin
			checks++;
			assert (hh < 24 && mm < 60 && ss < 60) else begin
				errors++;
				valid = 1'b0;
				$display("overlay shows %0d:%0d:%0d, not a time of day", hh, mm, ss);
			end
		end
		tod = valid ? hh * 3600 + mm * 60 + ss : -1;
	endtask

	task automatic run_photo(input dpa_pkg::im_addr_t fb, input dpa_pkg::im_addr_t photo,
			input int size, input dpa_pkg::pixel_t tod_bcd, input int limit,
			input bit need_wrap);
		int n;
		int tod;
		int prev;
		bit wrapped;
		reset_and_load(fb, photo, size, tod_bcd);
		wait_redraw();
		compare_frame(photo, size == `SRC_BIG);
		decode_overlay(prev);
		n = 1;
		wrapped = 1'b0;
		while (n < limit && !(need_wrap && wrapped)) begin
			wait_redraw();
			decode_overlay(tod);
			checks++;
			assert (tod == (prev + 1) % DAY) else begin
				errors++;
				$display("ERR overlay_time got %h exp %h", tod, (prev + 1) % DAY);
			end
			if (prev == DAY - 1 && tod == 0)
				wrapped = 1'b1;
			prev = tod;
			n++;
		end
		if (need_wrap) begin
			checks++;
			assert (wrapped) else begin
				errors++;
				$display("midnight rollover not seen within %0d redraws", limit);
			end
		end
	endtask

	initial begin : main
		int i;
		reset = 1'b1;
		seed = 32'h24f8601c;
		errors = 0;
		checks = 0;
		cur_fb = '0;
		for (i = 0; i < (1 << `CR_AW); i++)
			u_mem.rom[i] = `CR_DW'($random(seed));
		// 512 source close to midnight, rollover comes after the scan
		run_photo(20'h80000, 20'h10000, `SRC_BIG, 24'h235750, MAX_REDRAWS, 1'b1);
		run_photo(20'h40000, 20'hc0000, 256, 24'h100500, 4, 1'b0);
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout, runs not finished after %0d cycles", WATCHDOG_CYCLES);
		$display("checks %0d errors %0d", checks, errors);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+rtl
rtl/dpa_pkg.sv
rtl/mem_arbiter.sv
rtl/header_loader.sv
rtl/time_counter.sv
rtl/photo_scaler.sv
rtl/clock_overlay.sv
rtl/dpa_top.sv
tb/dpa_mem_model.sv
tb/tb_dpa.sv

/* Bender.yml */
package:
  name: dpa

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/dpa_pkg.sv
      - rtl/mem_arbiter.sv
      - rtl/header_loader.sv
      - rtl/time_counter.sv
      - rtl/photo_scaler.sv
      - rtl/clock_overlay.sv
      - rtl/dpa_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tb/dpa_mem_model.sv
      - tb/tb_dpa.sv
